// File: hdl/nabp_defines.svh
`ifndef NABP_DEFINES_SVH
`define NABP_DEFINES_SVH

// projection line geometry
`define NABP_LINE_LEN       8
`define NABP_LINE_IDX_W     3

// datapath widths
`define NABP_SAMPLE_W       12
`define NABP_ADDR_W         10
`define NABP_ITR_W          8

// apb bus widths
`define NABP_APB_ADDR_W     8
`define NABP_APB_DATA_W     32

// apb register map, byte offsets
`define NABP_REG_CTRL       8'h00
`define NABP_REG_NUM_ITR    8'h04
`define NABP_REG_SH_BASE    8'h08
`define NABP_REG_MP_INIT    8'h0C
`define NABP_REG_MP_BASE    8'h10
`define NABP_REG_MP_STEP    8'h14
`define NABP_REG_STATUS     8'h18

`endif

// File: hdl/nabp_pkg.sv
`default_nettype none

`include "nabp_defines.svh"

package nabp_pkg;

    // one projection sample
    typedef logic [`NABP_SAMPLE_W-1:0] sample_t;

    // line buffer index, also the rotation offset
    typedef logic [`NABP_LINE_IDX_W-1:0] line_idx_t;

    // accumulator address, mapper init, base and step
    typedef logic [`NABP_ADDR_W-1:0] addr_t;

    // iteration (projection angle) count
    typedef logic [`NABP_ITR_W-1:0] itr_t;

    typedef logic [`NABP_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`NABP_APB_DATA_W-1:0] apb_data_t;

    // processing sequence of one iteration
    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s
    } state_ctl_t;

endpackage

`default_nettype wire

// File: hdl/nabp_swap_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_swap_control (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire nabp_pkg::apb_addr_t paddr,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire nabp_pkg::apb_data_t pwdata,
    output nabp_pkg::apb_data_t      prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  wire                      sw_swap,
    input  wire                      sw_next_itr,
    output logic                     sw_next_itr_ack,
    output logic                     sw_swap_ack,
    output logic                     bank_sel,
    output nabp_pkg::line_idx_t      sw_sh_accu_base,
    output nabp_pkg::addr_t          sw_mp_accu_init,
    output nabp_pkg::addr_t          sw_mp_accu_base
);
    import nabp_pkg::*;

    itr_t      num_itr;
    line_idx_t sh_base;
    addr_t     mp_init;
    addr_t     mp_step;
    logic      busy;
    logic      done;
    logic      in_flight;
    itr_t      itr_cnt;
    itr_t      cpl_cnt;
    logic      sw_swap_d;
    logic      swap_rise;
    logic      apb_access;
    logic      apb_wr;
    logic      addr_hit;
    logic      start;
    apb_data_t rd_data;

    assign apb_access = psel && penable;
    assign apb_wr     = apb_access && pwrite && addr_hit;
    assign start      = apb_wr && (paddr == `NABP_REG_CTRL) && pwdata[0] && !busy;

    // address decode and read mux
    always_comb
    begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            `NABP_REG_CTRL:    rd_data = '0;
            `NABP_REG_NUM_ITR: rd_data = {24'd0, num_itr};
            `NABP_REG_SH_BASE: rd_data = {29'd0, sh_base};
            `NABP_REG_MP_INIT: rd_data = {22'd0, mp_init};
            `NABP_REG_MP_BASE: rd_data = {22'd0, sw_mp_accu_base};
            `NABP_REG_MP_STEP: rd_data = {22'd0, mp_step};
            `NABP_REG_STATUS:  rd_data = {16'd0, cpl_cnt, 6'd0, done, busy};
            default:           addr_hit = 1'b0;
        endcase
    end

    assign prdata  = (apb_access && !pwrite) ? rd_data : '0;
    assign pready  = 1'b1;
    assign pslverr = apb_access && !addr_hit;

    // configuration is frozen during a run
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            num_itr         <= '0;
            sh_base         <= '0;
            mp_init         <= '0;
            mp_step         <= '0;
            sw_mp_accu_base <= '0;
        end
        else if (apb_wr && !busy)
        begin
            case (paddr)
                `NABP_REG_NUM_ITR: num_itr         <= pwdata[`NABP_ITR_W-1:0];
                `NABP_REG_SH_BASE: sh_base         <= pwdata[`NABP_LINE_IDX_W-1:0];
                `NABP_REG_MP_INIT: mp_init         <= pwdata[`NABP_ADDR_W-1:0];
                `NABP_REG_MP_BASE: sw_mp_accu_base <= pwdata[`NABP_ADDR_W-1:0];
                `NABP_REG_MP_STEP: mp_step         <= pwdata[`NABP_ADDR_W-1:0];
                default:           ;
            endcase
        end
    end

    // run control, one ack per iteration while ready is requested
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy            <= 1'b0;
            done            <= 1'b0;
            in_flight       <= 1'b0;
            itr_cnt         <= '0;
            cpl_cnt         <= '0;
            sw_next_itr_ack <= 1'b0;
        end
        else
        begin
            sw_next_itr_ack <= 1'b0;
            if (start)
            begin
                busy      <= 1'b1;
                done      <= 1'b0;
                in_flight <= 1'b0;
                itr_cnt   <= '0;
                cpl_cnt   <= '0;
            end
            else if (busy && sw_next_itr && !sw_next_itr_ack)
            begin
                // back in ready means the previous shift has ended
                if (in_flight)
                    cpl_cnt <= cpl_cnt + itr_t'(1);
                in_flight <= 1'b0;
                if (itr_cnt != num_itr)
                begin
                    sw_next_itr_ack <= 1'b1;
                    itr_cnt         <= itr_cnt + itr_t'(1);
                    in_flight       <= 1'b1;
                end
                else
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // next iteration constants, moved on once the current ones are latched
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            sw_sh_accu_base <= sh_base;
            sw_mp_accu_init <= mp_init;
        end
        else if (sw_next_itr_ack)
        begin
            sw_sh_accu_base <= sw_sh_accu_base + line_idx_t'(1);
            sw_mp_accu_init <= sw_mp_accu_init + mp_step;
        end
    end

    assign swap_rise = sw_swap && !sw_swap_d;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sw_swap_d   <= 1'b0;
            sw_swap_ack <= 1'b0;
            bank_sel    <= 1'b0;
        end
        else
        begin
            sw_swap_d   <= sw_swap;
            sw_swap_ack <= swap_rise;
            if (swap_rise)
                bank_sel <= !bank_sel;
        end
    end

    // state control is still waiting when the ack arrives
    a_swap_ack: assert property (@(posedge clk) disable iff (!reset_n)
        sw_swap_ack |-> $past(sw_swap) && sw_swap);

endmodule

`default_nettype wire

// File: hdl/nabp_state_control.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_state_control (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire nabp_pkg::line_idx_t sw_sh_accu_base,
    input  wire nabp_pkg::addr_t     sw_mp_accu_init,
    input  wire nabp_pkg::addr_t     sw_mp_accu_base,
    input  wire                      sw_swap_ack,
    input  wire                      sw_next_itr_ack,
    input  wire                      sh_fill_done,
    input  wire                      sh_shift_done,
    output logic                     sw_swap,
    output logic                     sw_next_itr,
    output logic                     sh_fill_kick,
    output logic                     sh_shift_kick,
    output nabp_pkg::line_idx_t      sh_accu_base,
    output nabp_pkg::addr_t          mp_accu_init,
    output nabp_pkg::addr_t          mp_accu_base
);
    import nabp_pkg::*;

    state_ctl_t state;
    state_ctl_t next_state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= ready_s;
        else
            state <= next_state;
    end

    // constants track swap control until the iteration is granted
    always_ff @(posedge clk)
    begin
        if (state == ready_s)
        begin
            sh_accu_base <= sw_sh_accu_base;
            mp_accu_init <= sw_mp_accu_init;
            mp_accu_base <= sw_mp_accu_base;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (sw_next_itr_ack)
                    next_state = fill_s;
            fill_s:
                if (sh_fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (sw_swap_ack)
                    next_state = shift_s;
            shift_s:
                if (sh_shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // requests to swap control
    assign sw_swap     = (state == fill_done_s);
    assign sw_next_itr = reset_n && (state == ready_s);

    // kicks fire in the cycle before the new state is entered
    assign sh_fill_kick  = (next_state != state) && (next_state == fill_s);
    assign sh_shift_kick = (next_state != state) && (next_state == shift_s);

    // shifter reports completion only in the matching state
    a_fill_done_in_fill: assert property (@(posedge clk) disable iff (!reset_n)
        sh_fill_done |-> state == fill_s);

    a_shift_done_in_shift: assert property (@(posedge clk) disable iff (!reset_n)
        sh_shift_done |-> state == shift_s);

endmodule

`default_nettype wire

// File: hdl/nabp_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_shifter (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      sh_fill_kick,
    input  wire                      sh_shift_kick,
    input  wire nabp_pkg::line_idx_t sh_accu_base,
    input  wire                      bank_sel,
    input  wire                      sample_valid,
    input  wire nabp_pkg::sample_t   sample_data,
    output logic                     sample_ready,
    output logic                     sh_fill_done,
    output logic                     sh_shift_done,
    output logic                     sh_step,
    output logic                     out_valid,
    output nabp_pkg::sample_t        out_sample
);
    import nabp_pkg::*;

    localparam line_idx_t LAST_IDX = line_idx_t'(`NABP_LINE_LEN - 1);

    sample_t   bank_mem [0:1][0:`NABP_LINE_LEN-1];
    logic      filling;
    logic      shifting;
    line_idx_t fill_cnt;
    line_idx_t shift_cnt;
    line_idx_t rd_idx;
    logic      accept;

    assign sample_ready = filling;
    assign accept       = filling && sample_valid;

    // fill side writes the bank selected by swap control
    always_ff @(posedge clk)
    begin
        if (accept)
            bank_mem[bank_sel][fill_cnt] <= sample_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filling      <= 1'b0;
            fill_cnt     <= '0;
            sh_fill_done <= 1'b0;
        end
        else
        begin
            sh_fill_done <= accept && (fill_cnt == LAST_IDX);
            if (sh_fill_kick)
            begin
                filling  <= 1'b1;
                fill_cnt <= '0;
            end
            else if (accept)
            begin
                fill_cnt <= fill_cnt + line_idx_t'(1);
                if (fill_cnt == LAST_IDX)
                    filling <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            shifting  <= 1'b0;
            shift_cnt <= '0;
        end
        else if (sh_shift_kick)
        begin
            shifting  <= 1'b1;
            shift_cnt <= '0;
        end
        else if (shifting)
        begin
            shift_cnt <= shift_cnt + line_idx_t'(1);
            if (shift_cnt == LAST_IDX)
                shifting <= 1'b0;
        end
    end

    // rotated read from the bank filled last, index wraps at line length
    assign rd_idx        = sh_accu_base + shift_cnt;
    assign out_sample    = bank_mem[!bank_sel][rd_idx];
    assign out_valid     = shifting;
    assign sh_step       = shifting;
    assign sh_shift_done = shifting && (shift_cnt == LAST_IDX);

    a_no_ready_in_shift: assert property (@(posedge clk) disable iff (!reset_n)
        shifting |-> !sample_ready);

endmodule

`default_nettype wire

// File: hdl/nabp_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_mapper (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  sh_shift_kick,
    input  wire                  sh_step,
    input  wire nabp_pkg::addr_t mp_accu_init,
    input  wire nabp_pkg::addr_t mp_accu_base,
    output nabp_pkg::addr_t      out_addr
);

    // accumulator holds the address of the sample now at the output
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            out_addr <= '0;
        else if (sh_shift_kick)
            out_addr <= mp_accu_init;
        else if (sh_step)
            // wraps modulo the accumulator size
            out_addr <= out_addr + mp_accu_base;
    end

    // shifter presents its first sample right after the kick
    a_step_after_kick: assert property (@(posedge clk) disable iff (!reset_n)
        sh_shift_kick |=> sh_step);

endmodule

`default_nettype wire

// File: hdl/nabp_processing_top.sv
`timescale 1ns/1ps
`default_nettype none

module nabp_processing_top (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire nabp_pkg::apb_addr_t paddr,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire nabp_pkg::apb_data_t pwdata,
    output nabp_pkg::apb_data_t      prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  wire                      sample_valid,
    input  wire nabp_pkg::sample_t   sample_data,
    output logic                     sample_ready,
    output logic                     out_valid,
    output nabp_pkg::sample_t        out_sample,
    output nabp_pkg::addr_t          out_addr
);
    import nabp_pkg::*;

    // swap control to state control
    logic      sw_swap;
    logic      sw_next_itr;
    logic      sw_swap_ack;
    logic      sw_next_itr_ack;
    logic      bank_sel;
    line_idx_t sw_sh_accu_base;
    addr_t     sw_mp_accu_init;
    addr_t     sw_mp_accu_base;

    // state control to shifter and mapper
    logic      sh_fill_kick;
    logic      sh_shift_kick;
    logic      sh_fill_done;
    logic      sh_shift_done;
    logic      sh_step;
    line_idx_t sh_accu_base;
    addr_t     mp_accu_init;
    addr_t     mp_accu_base;

    nabp_swap_control u_swap_control (
        .clk             (clk),
        .reset_n         (reset_n),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sw_next_itr_ack (sw_next_itr_ack),
        .sw_swap_ack     (sw_swap_ack),
        .bank_sel        (bank_sel),
        .sw_sh_accu_base (sw_sh_accu_base),
        .sw_mp_accu_init (sw_mp_accu_init),
        .sw_mp_accu_base (sw_mp_accu_base)
    );

    nabp_state_control u_state_control (
        .clk             (clk),
        .reset_n         (reset_n),
        .sw_sh_accu_base (sw_sh_accu_base),
        .sw_mp_accu_init (sw_mp_accu_init),
        .sw_mp_accu_base (sw_mp_accu_base),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .sh_fill_done    (sh_fill_done),
        .sh_shift_done   (sh_shift_done),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sh_fill_kick    (sh_fill_kick),
        .sh_shift_kick   (sh_shift_kick),
        .sh_accu_base    (sh_accu_base),
        .mp_accu_init    (mp_accu_init),
        .mp_accu_base    (mp_accu_base)
    );

    nabp_shifter u_shifter (
        .clk           (clk),
        .reset_n       (reset_n),
        .sh_fill_kick  (sh_fill_kick),
        .sh_shift_kick (sh_shift_kick),
        .sh_accu_base  (sh_accu_base),
        .bank_sel      (bank_sel),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .sample_ready  (sample_ready),
        .sh_fill_done  (sh_fill_done),
        .sh_shift_done (sh_shift_done),
        .sh_step       (sh_step),
        .out_valid     (out_valid),
        .out_sample    (out_sample)
    );

    nabp_mapper u_mapper (
        .clk           (clk),
        .reset_n       (reset_n),
        .sh_shift_kick (sh_shift_kick),
        .sh_step       (sh_step),
        .mp_accu_init  (mp_accu_init),
        .mp_accu_base  (mp_accu_base),
        .out_addr      (out_addr)
    );

endmodule

`default_nettype wire

// File: sim/nabp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nabp_defines.svh"

module nabp_tb;
    import nabp_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_SEED    = 14418;
    localparam int LINE_LEN     = `NABP_LINE_LEN;
    localparam int ADDR_SPAN    = 1 << `NABP_ADDR_W;

    // watchdog budget, iterations summed over all five tests
    localparam int NUM_TESTS       = 5;
    localparam int TOTAL_ITRS      = 8;
    localparam int ITR_CYCLES      = 40;
    localparam int APB_CYCLES      = 120;
    localparam int WATCHDOG_CYCLES = 2 * (2 * RESET_CYCLES + TOTAL_ITRS * ITR_CYCLES
                                          + NUM_TESTS * APB_CYCLES);
    localparam int POLL_LIMIT      = 64;
    localparam int OUT_WAIT_LIMIT  = 64;

    logic      clk;
    logic      reset_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      sample_valid;
    sample_t   sample_data;
    logic      sample_ready;
    logic      out_valid;
    sample_t   out_sample;
    addr_t     out_addr;

    int        checks;
    int        errors;
    int        tests_run;
    sample_t   line_data  [0:LINE_LEN-1];
    sample_t   got_sample [0:LINE_LEN-1];
    addr_t     got_addr   [0:LINE_LEN-1];

    nabp_processing_top i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .out_valid    (out_valid),
        .out_sample   (out_sample),
        .out_addr     (out_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error at %0t: run did not finish within %0d cycles", $time, WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    task automatic report_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - errors_at_start);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n      <= 1'b0;
        sample_valid <= 1'b0;
        psel         <= 1'b0;
        penable      <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    // setup phase, access phase, response sampled mid access cycle
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_flag("pready", pready, 1'b1);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_flag("pready", pready, 1'b1);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_readback(input apb_addr_t addr, input apb_data_t value,
                                  input string name);
        apb_data_t rd;
        logic      err;
        apb_write(addr, value, err);
        check_flag("pslverr on write", err, 1'b0);
        apb_read(addr, rd, err);
        check_flag("pslverr on read", err, 1'b0);
        check_word(name, rd, value);
    endtask

    task automatic configure_run(input int num_itr, input int sh_base, input int mp_init,
                                 input int mp_base, input int mp_step);
        logic err;
        apb_write(`NABP_REG_NUM_ITR, apb_data_t'(num_itr), err);
        apb_write(`NABP_REG_SH_BASE, apb_data_t'(sh_base), err);
        apb_write(`NABP_REG_MP_INIT, apb_data_t'(mp_init), err);
        apb_write(`NABP_REG_MP_BASE, apb_data_t'(mp_base), err);
        apb_write(`NABP_REG_MP_STEP, apb_data_t'(mp_step), err);
        apb_write(`NABP_REG_CTRL, apb_data_t'(1), err);
    endtask

    task automatic fill_line_data();
        for (int k = 0; k < LINE_LEN; k++)
            line_data[line_idx_t'(k)] = sample_t'($urandom);
    endtask

    // junk data during gaps must never land in the buffer
    task automatic send_line(input int count, input bit gaps);
        int gap;
        for (int k = 0; k < count; k++)
        begin
            gap = gaps ? int'($urandom_range(3, 0)) : 0;
            repeat (gap)
            begin
                @(posedge clk);
                sample_valid <= 1'b0;
                sample_data  <= sample_t'($urandom);
            end
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_data  <= line_data[line_idx_t'(k)];
            @(negedge clk);
            while (!sample_ready)
                @(negedge clk);
        end
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    task automatic collect_line(output bit line_ok);
        int wait_cnt;
        wait_cnt = 0;
        line_ok  = 1'b1;
        @(negedge clk);
        while (!out_valid && wait_cnt < OUT_WAIT_LIMIT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!out_valid)
        begin
            report_error("no output line appeared after the fill");
            line_ok = 1'b0;
        end
        else
        begin
            for (int k = 0; k < LINE_LEN; k++)
            begin
                if (!out_valid)
                    report_error("out_valid dropped inside an output line");
                got_sample[line_idx_t'(k)] = out_sample;
                got_addr[line_idx_t'(k)]   = out_addr;
                @(negedge clk);
            end
            check_flag("out_valid after line", out_valid, 1'b0);
        end
    endtask

    // expected rotation and address sequence for iteration itr
    task automatic check_line(input int itr, input int sh_base, input int mp_init,
                              input int mp_base, input int mp_step);
        int        offset;
        int        init;
        line_idx_t idx;
        sample_t   exp_sample;
        addr_t     exp_addr;
        offset = (sh_base + itr) % LINE_LEN;
        init   = (mp_init + itr * mp_step) % ADDR_SPAN;
        for (int k = 0; k < LINE_LEN; k++)
        begin
            idx        = line_idx_t'((offset + k) % LINE_LEN);
            exp_sample = line_data[idx];
            exp_addr   = addr_t'((init + k * mp_base) % ADDR_SPAN);
            check_sample($sformatf("out_sample[%0d]", k), got_sample[line_idx_t'(k)], exp_sample);
            check_addr($sformatf("out_addr[%0d]", k), got_addr[line_idx_t'(k)], exp_addr);
        end
    endtask

    task automatic wait_done(input int exp_count);
        apb_data_t status;
        apb_data_t exp_status;
        logic      err;
        int        polls;
        polls = 0;
        apb_read(`NABP_REG_STATUS, status, err);
        while (!status[1] && polls < POLL_LIMIT)
        begin
            apb_read(`NABP_REG_STATUS, status, err);
            polls++;
        end
        if (!status[1])
            report_error("run never reported done in STATUS");
        else
        begin
            // count in 15:8, done set, busy clear
            exp_status = (apb_data_t'(exp_count) << 8) | apb_data_t'(2);
            check_word("STATUS", status, exp_status);
        end
    endtask

    task automatic run_lines(input int num_itr, input int sh_base, input int mp_init,
                             input int mp_base, input int mp_step, input bit gaps);
        bit line_ok;
        configure_run(num_itr, sh_base, mp_init, mp_base, mp_step);
        for (int i = 0; i < num_itr; i++)
        begin
            fill_line_data();
            send_line(LINE_LEN, gaps);
            collect_line(line_ok);
            if (line_ok)
                check_line(i, sh_base, mp_init, mp_base, mp_step);
        end
        wait_done(num_itr);
    endtask

    task automatic test_register_readback();
        int        err_start;
        apb_data_t rd;
        logic      err;
        err_start = errors;
        apb_read(`NABP_REG_STATUS, rd, err);
        check_word("STATUS after reset", rd, '0);
        write_readback(`NABP_REG_NUM_ITR, 32'h5A, "NUM_ITR");
        write_readback(`NABP_REG_SH_BASE, 32'h5, "SH_BASE");
        write_readback(`NABP_REG_MP_INIT, 32'h2A7, "MP_INIT");
        write_readback(`NABP_REG_MP_BASE, 32'h13C, "MP_BASE");
        write_readback(`NABP_REG_MP_STEP, 32'h0F1, "MP_STEP");
        apb_read(`NABP_REG_CTRL, rd, err);
        check_word("CTRL", rd, '0);
        apb_read(8'h1C, rd, err);
        check_flag("pslverr on unmapped read", err, 1'b1);
        apb_write(8'h40, 32'h1, err);
        check_flag("pslverr on unmapped write", err, 1'b1);
        report_test("register readback", err_start);
    endtask

    task automatic test_single_iteration();
        int err_start;
        err_start = errors;
        run_lines(1, 5, 1000, 9, 11, 1'b0);
        report_test("single iteration", err_start);
    endtask

    task automatic test_multi_iteration();
        int err_start;
        err_start = errors;
        // offsets wrap past 7, init wraps past 1023
        run_lines(4, 6, 200, 130, 300, 1'b0);
        report_test("multiple iterations", err_start);
    endtask

    task automatic test_input_gaps();
        int err_start;
        err_start = errors;
        run_lines(1, 2, 17, 129, 0, 1'b1);
        report_test("input gaps", err_start);
    endtask

    task automatic test_reset_during_fill();
        int        err_start;
        apb_data_t rd;
        logic      err;
        err_start = errors;
        configure_run(2, 3, 100, 7, 50);
        fill_line_data();
        send_line(3, 1'b0);
        apply_reset();
        @(negedge clk);
        check_flag("out_valid after reset", out_valid, 1'b0);
        check_flag("sample_ready after reset", sample_ready, 1'b0);
        apb_read(`NABP_REG_STATUS, rd, err);
        check_word("STATUS after reset", rd, '0);
        apb_read(`NABP_REG_NUM_ITR, rd, err);
        check_word("NUM_ITR after reset", rd, '0);
        run_lines(1, 6, 900, 77, 0, 1'b0);
        report_test("reset during fill", err_start);
    endtask

    initial
    begin
        reset_n      = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        sample_valid = 1'b0;
        sample_data  = '0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        void'($urandom(RAND_SEED));

        apply_reset();
        test_register_readback();
        test_single_iteration();
        test_multi_iteration();
        test_input_gaps();
        test_reset_during_fill();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: nabp.f
+incdir+hdl
hdl/nabp_pkg.sv
hdl/nabp_swap_control.sv
hdl/nabp_state_control.sv
hdl/nabp_shifter.sv
hdl/nabp_mapper.sv
hdl/nabp_processing_top.sv
sim/nabp_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= nabp_tb
FILELIST  ?= nabp.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
